//--- source/av_out_pkg.sv
// Shared video and audio types for the RTG and aux audio output stage, imported by every module
package av_out_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int PIX_CNT_W = 4;                     // Clocks-per-pixel counter width
  localparam int VB_CNT_W  = 6;                     // Vertical blank line counter width

  typedef logic [PIX_CNT_W-1:0] pix_cnt_t;          // Clocks per fetch minus one
  typedef logic [VB_CNT_W-1:0]  vb_cnt_t;           // Lines of RTG vertical blank

  //////////////////////////////////////////////////
  // Video
  //////////////////////////////////////////////////

  typedef logic [7:0]  color8_t;                    // One colour channel
  typedef logic [15:0] pixel_word_t;                // Raw RTG pixel word from the stream

  typedef struct packed {
    color8_t red;
    color8_t green;
    color8_t blue;
  } rgb_t;                                          // 24 bit colour

  typedef struct packed {
    logic hs;
    logic vs;
  } sync_t;

  typedef struct packed {
    sync_t sync;                                    // Upper two bits
    rgb_t  rgb;
  } video_t;                                        // Native in and final out

  typedef struct packed {
    logic window;                                   // OSD box active
    logic pixel;                                    // OSD foreground dot
  } osd_t;

  typedef struct packed {
    logic     enable;                               // RTG screen on
    logic     hicolor16;                            // 1 = RGB565, 0 = RGB555
    pix_cnt_t pixel_width;
    vb_cnt_t  vb_lines;
  } rtg_mode_t;                                     // 12 bits

  //////////////////////////////////////////////////
  // Audio
  //////////////////////////////////////////////////

  typedef logic signed [15:0] sample_t;             // Two's complement sample
  typedef logic [15:0]        dac_level_t;          // Offset binary DAC input
  typedef logic [16:0]        dac_acc_t;            // Accumulator plus carry

  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;                                       // 32 bits

endpackage

//--- source/rtg_fetch_timer.sv
// Generates RTG blanking from hblank, vblank and counted hsync lines, plus the pixel fetch strobe
`timescale 1ns/1ns

module rtg_fetch_timer import av_out_pkg::*; (
  input  logic      clk_114,
  input  logic      reset,
  input  rtg_mode_t mode,                           // Enable, width, vblank length
  input  logic      hblank,                         // Native horizontal blank
  input  logic      vblank,                         // Native vertical blank
  input  logic      native_hs,                      // Native hsync, edges count lines
  output logic      rtg_fetch,                      // One cycle, advance pixel stream
  output logic      rtg_blank                       // RTG area blanked
);

  typedef enum logic {
    VB_ACTIVE,                                      // Past the RTG top border
    VB_LINES                                        // Counting lines after vblank
  } vb_state_t;

  vb_state_t vb_state;
  vb_cnt_t   line_cnt;                              // Lines since vblank fell
  pix_cnt_t  pix_cnt;                               // Clocks since last fetch
  logic      hs_d;                                  // Previous hsync level
  logic      hs_rise;
  logic      lines_done;
  logic      vert_blank;

  //////////////////////////////////////////////////
  // Vertical blank
  //////////////////////////////////////////////////

  assign hs_rise    = native_hs & ~hs_d;            // New line starts
  assign lines_done = (line_cnt == mode.vb_lines);

  // Blank straight away on vblank, then hold until enough lines have passed
  assign vert_blank = vblank | ((vb_state == VB_LINES) & ~lines_done);

  always_ff @(posedge clk_114) begin
    if (reset) begin
      hs_d     <= 1'b0;
      vb_state <= VB_ACTIVE;
      line_cnt <= '0;
    end else begin
      hs_d <= native_hs;
      if (vblank) begin
        vb_state <= VB_LINES;                       // Restart every frame
        line_cnt <= '0;
      end else if (vb_state == VB_LINES) begin
        if (lines_done) begin
          vb_state <= VB_ACTIVE;                    // Count already reached
        end else if (hs_rise) begin
          line_cnt <= line_cnt + vb_cnt_t'(1);      // One more line gone
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Pixel fetch
  //////////////////////////////////////////////////

  assign rtg_blank = vert_blank | hblank;

  // Strobe once the counter reaches the programmed width
  assign rtg_fetch = mode.enable & ~rtg_blank & (pix_cnt == mode.pixel_width);

  always_ff @(posedge clk_114) begin
    if (reset) begin
      pix_cnt <= '0;
    end else if (rtg_blank || rtg_fetch) begin
      pix_cnt <= '0;                                // Realign on blank and after fetch
    end else begin
      pix_cnt <= pix_cnt + pix_cnt_t'(1);
    end
  end

endmodule

//--- source/video_mixer.sv
// Expands RTG hi-colour pixels, picks RTG or native colour, overlays the OSD and registers sync/RGB
`timescale 1ns/1ns

module video_mixer import av_out_pkg::*; (
  input  logic        clk_114,
  input  logic        reset,
  input  rtg_mode_t   mode,                         // Enable and pixel format used here
  input  logic        rtg_blank,                    // From fetch timer
  input  pixel_word_t rtg_pixel,                    // Head of the pixel stream
  input  video_t      native_video,                 // Chipset sync and colour
  input  osd_t        osd,                          // OSD window and dot
  input  logic        hsync_pol,                    // 1 inverts hsync
  input  logic        vsync_pol,                    // 1 inverts vsync
  output video_t      video_out
);

  rgb_t  rtg_rgb;                                   // Expanded pixel
  rgb_t  sel_rgb;                                   // RTG or native
  rgb_t  mix_rgb;                                   // After OSD
  sync_t sync_next;
  logic  blank_d1;
  logic  blank_d2;                                  // Lines up with the pixel data
  logic  use_rtg;
  logic  [1:0] osd_rg_bits;
  logic  [1:0] osd_b_bits;

  // Two OSD bits on top, the colour shifted down underneath
  function automatic color8_t osd_channel(input color8_t c, input logic [1:0] bits);
    return {bits, c[7:2]};
  endfunction

  //////////////////////////////////////////////////
  // Hi-colour expansion
  //////////////////////////////////////////////////

  always_comb begin
    if (mode.hicolor16) begin                       // RGB565
      rtg_rgb.red   = {rtg_pixel[15:11], rtg_pixel[15:13]};
      rtg_rgb.green = {rtg_pixel[10:5], rtg_pixel[10:9]};
    end else begin                                  // RGB555, bit 15 unused
      rtg_rgb.red   = {rtg_pixel[14:10], rtg_pixel[14:12]};
      rtg_rgb.green = {rtg_pixel[9:5], rtg_pixel[9:7]};
    end
    rtg_rgb.blue = {rtg_pixel[4:0], rtg_pixel[4:2]}; // Same in both formats
  end

  //////////////////////////////////////////////////
  // Selection and overlay
  //////////////////////////////////////////////////

  assign use_rtg = mode.enable & ~blank_d2;
  assign sel_rgb = use_rtg ? rtg_rgb : native_video.rgb;

  assign osd_rg_bits = osd.pixel ? 2'b11 : 2'b00;   // White dot or dark
  assign osd_b_bits  = osd.pixel ? 2'b11 : 2'b10;   // Bluish background

  always_comb begin
    mix_rgb = sel_rgb;
    if (osd.window) begin
      mix_rgb.red   = osd_channel(sel_rgb.red, osd_rg_bits);
      mix_rgb.green = osd_channel(sel_rgb.green, osd_rg_bits);
      mix_rgb.blue  = osd_channel(sel_rgb.blue, osd_b_bits);
    end
  end

  assign sync_next.hs = native_video.sync.hs ^ hsync_pol;
  assign sync_next.vs = native_video.sync.vs ^ vsync_pol;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset) begin
      blank_d1  <= 1'b1;                            // Start blanked
      blank_d2  <= 1'b1;
      video_out <= '0;
    end else begin
      blank_d1       <= rtg_blank;
      blank_d2       <= blank_d1;
      video_out.sync <= sync_next;
      video_out.rgb  <= mix_rgb;
    end
  end

endmodule

//--- source/aux_audio_sampler.sv
// Sample-rate tick for the aux audio stream, latching byte-swapped left then right samples
`timescale 1ns/1ns

module aux_audio_sampler import av_out_pkg::*; #(
  parameter int TICK_PERIOD = 643                   // Clocks per stereo sample, at least 2
) (
  input  logic    clk_114,
  input  logic    reset,
  input  sample_t aux_sample,                       // Head of the audio stream
  output logic    aux_next,                         // Advance the stream
  output stereo_t aux_audio                         // Latched stereo pair
);

  localparam int TICK_W = (TICK_PERIOD > 1) ? $clog2(TICK_PERIOD) : 1;

  logic [TICK_W-1:0] tick_cnt;                      // Modulo TICK_PERIOD
  logic              tick;                          // Left word cycle
  logic              tick_d;                        // Right word cycle

  // Stream words arrive little endian
  function automatic sample_t byte_swap(input sample_t s);
    return {s[7:0], s[15:8]};
  endfunction

  //////////////////////////////////////////////////
  // Rate tick
  //////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
      tick_d   <= 1'b0;
    end else begin
      tick_d <= tick;
      if (tick_cnt == TICK_W'(TICK_PERIOD - 1)) begin
        tick_cnt <= '0;                             // Wrap
        tick     <= 1'b1;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
        tick     <= 1'b0;
      end
    end
  end

  // Two words per tick, so two pulses
  assign aux_next = tick | tick_d;

  //////////////////////////////////////////////////
  // Sample latches
  //////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset) begin
      aux_audio <= '0;
    end else begin
      if (tick) begin
        aux_audio.left <= byte_swap(aux_sample);    // Even word
      end
      if (tick_d) begin
        aux_audio.right <= byte_swap(aux_sample);   // Odd word, stream has moved on
      end
    end
  end

endmodule

//--- source/audio_mix_dac.sv
// Saturating mix of native and aux audio into two first-order sigma-delta DAC bitstreams
`timescale 1ns/1ns

module audio_mix_dac import av_out_pkg::*; (
  input  logic    clk_114,
  input  logic    reset,
  input  stereo_t amiga_audio,                      // Native Paula output
  input  stereo_t aux_audio,                        // Latched aux samples
  output logic    audio_l,                          // Left bitstream
  output logic    audio_r                           // Right bitstream
);

  sample_t    mix [2];                              // 0 left, 1 right
  dac_level_t level [2];                            // Offset binary
  dac_acc_t   acc [2];                              // Carry in bit 16

  // Add with clamp to the signed 16 bit range
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic [16:0] sum;
    sum = {a[15], a} + {b[15], b};                  // Sign extended
    if (sum[16] != sum[15]) begin
      return sum[16] ? 16'sh8000 : 16'sh7fff;       // Overflow, clamp by sign
    end
    return sum[15:0];
  endfunction

  //////////////////////////////////////////////////
  // Mix and offset conversion
  //////////////////////////////////////////////////

  always_comb begin
    mix[0] = sat_add(amiga_audio.left, aux_audio.left);
    mix[1] = sat_add(amiga_audio.right, aux_audio.right);
    for (int ch = 0; ch < 2; ch++) begin
      level[ch] = {~mix[ch][15], mix[ch][14:0]};    // -32768 maps to 0
    end
  end

  //////////////////////////////////////////////////
  // Sigma-delta modulators
  //////////////////////////////////////////////////

  // Carry density tracks level/65536
  always_ff @(posedge clk_114) begin
    if (reset) begin
      for (int ch = 0; ch < 2; ch++) begin
        acc[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        acc[ch] <= {1'b0, acc[ch][15:0]} + {1'b0, level[ch]}; // Drop old carry
      end
    end
  end

  assign audio_l = acc[0][16];
  assign audio_r = acc[1][16];

endmodule

//--- source/av_output_top.sv
// Top of the RTG video and aux audio output stage, all on clk_114
`timescale 1ns/1ns

module av_output_top import av_out_pkg::*; #(
  parameter int TICK_PERIOD = 643                   // Aux audio sample period in clocks
) (
  input  logic        clk_114,
  input  logic        reset,
  // Video
  input  video_t      native_video,
  input  logic        hblank,
  input  logic        vblank,
  input  osd_t        osd,
  input  rtg_mode_t   rtg_mode,
  input  logic        hsync_pol,
  input  logic        vsync_pol,
  input  pixel_word_t rtg_pixel,                    // Pixel stream head
  output logic        rtg_fetch,                    // Pixel stream advance
  output video_t      video_out,
  // Audio
  input  stereo_t     amiga_audio,
  input  sample_t     aux_sample,                   // Audio stream head
  output logic        aux_next,                     // Audio stream advance
  output logic        audio_l,
  output logic        audio_r
);

  logic    rtg_blank;                               // Timer to mixer
  stereo_t aux_audio;                               // Sampler to DAC

  //////////////////////////////////////////////////
  // Video section
  //////////////////////////////////////////////////

  rtg_fetch_timer rtg_fetch_timer_inst (
    .clk_114   (clk_114),
    .reset     (reset),
    .mode      (rtg_mode),
    .hblank    (hblank),
    .vblank    (vblank),
    .native_hs (native_video.sync.hs),              // Line edges for vblank count
    .rtg_fetch (rtg_fetch),
    .rtg_blank (rtg_blank)
  );

  video_mixer video_mixer_inst (
    .clk_114      (clk_114),
    .reset        (reset),
    .mode         (rtg_mode),
    .rtg_blank    (rtg_blank),
    .rtg_pixel    (rtg_pixel),
    .native_video (native_video),
    .osd          (osd),
    .hsync_pol    (hsync_pol),
    .vsync_pol    (vsync_pol),
    .video_out    (video_out)
  );

  //////////////////////////////////////////////////
  // Audio section
  //////////////////////////////////////////////////

  aux_audio_sampler #(
    .TICK_PERIOD (TICK_PERIOD)
  ) aux_audio_sampler_inst (
    .clk_114    (clk_114),
    .reset      (reset),
    .aux_sample (aux_sample),
    .aux_next   (aux_next),
    .aux_audio  (aux_audio)
  );

  audio_mix_dac audio_mix_dac_inst (
    .clk_114     (clk_114),
    .reset       (reset),
    .amiga_audio (amiga_audio),
    .aux_audio   (aux_audio),
    .audio_l     (audio_l),
    .audio_r     (audio_r)
  );

endmodule

//--- verification/av_output_checker.sv
// Assertions on the fetch and aux strobes, bound into the fetch timer and the aux sampler
`timescale 1ns/1ns

module av_output_checker #(
  parameter bit PAIRED = 1'b0                        // Strobe comes in two-cycle pairs
) (
  input logic clk_114,
  input logic reset,
  input logic strobe,                                // rtg_fetch or aux_next
  input logic blank                                  // Strobe must stay low here
);

  //////////////////////////////////////////////////
  // Blank and reset
  //////////////////////////////////////////////////

  property no_strobe_in_blank;
    @(posedge clk_114) disable iff (reset)
      blank |-> !strobe;
  endproperty

  property quiet_after_reset;
    @(posedge clk_114) reset |=> !strobe;            // First cycle out of reset too
  endproperty

  generate
    if (!PAIRED) begin : g_blank                     // Only the fetch strobe has a blank
      blank_chk: assert property (no_strobe_in_blank)
        else $error("strobe high while blanked");
    end
  endgenerate

  reset_chk: assert property (quiet_after_reset)
    else $error("strobe high in the cycle after reset");

  //////////////////////////////////////////////////
  // Pairing
  //////////////////////////////////////////////////

  generate
    if (PAIRED) begin : g_pair
      pair_chk: assert property (@(posedge clk_114) disable iff (reset)
          $rose(strobe) |=> strobe ##1 !strobe)      // Left word, right word, gap
        else $error("strobe pulses not in adjacent pairs");
    end
  endgenerate

endmodule

bind rtg_fetch_timer av_output_checker #(.PAIRED(1'b0)) fetch_checker (
  .clk_114 (clk_114),
  .reset   (reset),
  .strobe  (rtg_fetch),
  .blank   (rtg_blank)
);

bind aux_audio_sampler av_output_checker #(.PAIRED(1'b1)) aux_checker (
  .clk_114 (clk_114),
  .reset   (reset),
  .strobe  (aux_next),
  .blank   (1'b0)
);

//--- verification/av_output_tb.sv
// Testbench for av_output_top, runs the steps in av_patterns.txt against stream models
`timescale 1ns/1ns

module av_output_tb import av_out_pkg::*; ();

  localparam int          TICK_PERIOD = 40;          // Short aux period for simulation
  localparam int          WAIT_LIMIT  = 2000;        // Cycles before a wait gives up
  localparam logic [31:0] LFSR_SEED   = 32'h9632cf4c;

  logic        clk_114 = 1'b0;
  logic        reset = 1'b1;
  video_t      native_video = '0;
  logic        hblank = 1'b0;
  logic        vblank = 1'b0;
  osd_t        osd = '0;
  rtg_mode_t   rtg_mode = '0;
  logic        hsync_pol = 1'b0;
  logic        vsync_pol = 1'b0;
  pixel_word_t rtg_pixel = '0;                       // Driven by the stream model
  stereo_t     amiga_audio = '0;
  sample_t     aux_sample = '0;                      // Driven by the stream model
  logic        rtg_fetch;
  video_t      video_out;
  logic        aux_next;
  logic        audio_l;
  logic        audio_r;

  logic        [31:0] lfsr = LFSR_SEED;
  logic        fetch_seen = 1'b0;                    // Strobe seen at last rising edge
  logic        aux_seen = 1'b0;
  logic        pix_hold = 1'b0;                      // Repeat one known pixel word
  logic        aux_hold = 1'b0;                      // Repeat one known audio word
  pixel_word_t pix_hold_word = '0;
  logic        [15:0] aux_hold_word = '0;
  logic        [15:0] aux_log [$];                   // Audio words the DUT consumed
  logic        timed_out = 1'b0;                     // Some wait ran out, stop the steps
  int          cyc_cnt = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  av_output_top #(.TICK_PERIOD(TICK_PERIOD)) av_output_top_inst (
    .clk_114, .reset, .native_video, .hblank, .vblank, .osd, .rtg_mode,
    .hsync_pol, .vsync_pol, .rtg_pixel, .rtg_fetch, .video_out,
    .amiga_audio, .aux_sample, .aux_next, .audio_l, .audio_r
  );

  always #50 clk_114 = ~clk_114;                     // 100 ns period

  //////////////////////////////////////////////////
  // Stream models
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Taps 32 22 2 1
  endfunction

  task automatic take_word(output logic [15:0] w);
    for (int i = 0; i < 16; i++) begin
      w[i] = lfsr[0];                                // One step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  always @(posedge clk_114) begin
    fetch_seen <= rtg_fetch;
    aux_seen   <= aux_next;
    cyc_cnt    <= cyc_cnt + 1;
  end

  always @(negedge clk_114) begin : stream_model
    logic [15:0] w;
    if (pix_hold) begin
      rtg_pixel = pix_hold_word;
    end else if (fetch_seen) begin
      take_word(w);                                  // Head consumed, next word
      rtg_pixel = w;
    end
    if (aux_seen) begin
      aux_log.push_back(aux_sample);
    end
    if (aux_hold) begin
      aux_sample = aux_hold_word;
    end else if (aux_seen) begin
      take_word(w);
      aux_sample = w;
    end
  end

  //////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      other_errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  // Ones over a window against window*U/65536, one count of slack
  task automatic check_density(input string name, input int ones, input int window,
                               input logic [15:0] u);
    longint diff;
    diff = longint'(ones) * 65536 - longint'(window) * longint'(u);
    assert (diff <= 65536 && diff >= -65536) else begin
      value_errors++;
      $display("** Error at %0t ns: %s ones expected %0d, got %0d", $time, name,
               (window * int'(u)) / 65536, ones);
    end
  endtask

  task automatic print_counts();
    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    other_errors++;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  task automatic wait_fetch(output int n);
    n = 0;
    do begin
      @(negedge clk_114);
      n++;
    end while (!rtg_fetch && n < WAIT_LIMIT);
    if (!rtg_fetch) report_timeout("rtg_fetch never pulsed");
  endtask

  // First cycle of the next aux_next pair
  task automatic wait_aux_start();
    int n;
    n = 0;
    while (aux_next && n < WAIT_LIMIT) begin
      @(negedge clk_114);
      n++;
    end
    if (aux_next) begin
      report_timeout("aux_next never went low");
    end else begin
      n = 0;
      do begin
        @(negedge clk_114);
        n++;
      end while (!aux_next && n < WAIT_LIMIT);
      if (!aux_next) report_timeout("aux_next never pulsed");
    end
  endtask

  function automatic logic [15:0] offset_of(input logic [15:0] raw);
    logic [15:0] swapped;
    swapped = {raw[7:0], raw[15:8]};                 // Stream is little endian
    return swapped + 16'h8000;                       // Signed to offset binary
  endfunction

  //////////////////////////////////////////////////
  // Test steps
  //////////////////////////////////////////////////

  task automatic run_fetch(input int pw, input int lines);
    int n;
    rtg_mode.enable      = 1'b1;
    rtg_mode.pixel_width = pix_cnt_t'(pw);
    rtg_mode.vb_lines    = vb_cnt_t'(lines);
    native_video.sync.hs = 1'b0;
    hblank = 1'b0;
    vblank = 1'b1;
    repeat (2) @(negedge clk_114);
    vblank = 1'b0;
    for (int i = 0; i < lines; i++) begin
      repeat (3) begin
        @(negedge clk_114);
        check_true(!rtg_fetch, "rtg_fetch during vertical blank");
      end
      native_video.sync.hs = 1'b1;                   // Line edge
      if (i < lines - 1) begin
        repeat (2) begin
          @(negedge clk_114);
          check_true(!rtg_fetch, "rtg_fetch during vertical blank");
        end
        native_video.sync.hs = 1'b0;
      end
    end
    wait_fetch(n);
    check_value("rtg_fetch delay after vblank", pw + 1, n);
    repeat (4) begin
      wait_fetch(n);
      check_value("rtg_fetch spacing", pw + 1, n);
    end
    hblank = 1'b1;
    repeat (8) begin
      @(negedge clk_114);
      check_true(!rtg_fetch, "rtg_fetch during hblank");
    end
    hblank = 1'b0;
    wait_fetch(n);
    check_value("rtg_fetch delay after hblank", (pw == 0) ? 1 : pw, n);
    native_video.sync.hs = 1'b0;
  endtask

  task automatic run_aux(input int pairs);
    int start;
    int ones_l;
    int ones_r;
    amiga_audio = '0;
    aux_hold = 1'b0;
    wait_aux_start();
    for (int p = 0; p < pairs; p++) begin
      start = cyc_cnt;
      @(negedge clk_114);
      check_true(aux_next, "aux_next pulse without its partner");
      @(negedge clk_114);
      check_true(!aux_next, "aux_next high for more than two cycles");
      ones_l = 0;
      ones_r = 0;
      repeat (32) begin                              // Both latches now hold the pair
        @(negedge clk_114);
        ones_l += int'(audio_l);
        ones_r += int'(audio_r);
      end
      check_density("audio_l", ones_l, 32, offset_of(aux_log[aux_log.size() - 2]));
      check_density("audio_r", ones_r, 32, offset_of(aux_log[aux_log.size() - 1]));
      wait_aux_start();
      check_value("aux_next period", TICK_PERIOD, cyc_cnt - start);
    end
  endtask

  task automatic run_mix(input logic [31:0] amiga, input logic [15:0] word,
                         input logic [15:0] u_l, input logic [15:0] u_r);
    int ones_l;
    int ones_r;
    amiga_audio   = amiga;
    aux_hold_word = word;
    aux_hold      = 1'b1;
    repeat (2) begin                                 // Flush both latches
      wait_aux_start();
      repeat (3) @(negedge clk_114);
    end
    ones_l = 0;
    ones_r = 0;
    repeat (1024) begin
      @(negedge clk_114);
      ones_l += int'(audio_l);
      ones_r += int'(audio_r);
    end
    check_density("audio_l", ones_l, 1024, u_l);
    check_density("audio_r", ones_r, 1024, u_r);
    aux_hold = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int          fd;
    string       line;
    logic [31:0] tag;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    repeat (3) @(negedge clk_114);                   // Reset over 3 rising edges
    reset = 1'b0;
    fd = $fopen("verification/av_patterns.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Error: could not open the pattern file");
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        f4 = '0;
        void'($sscanf(line, "%h %h %h %h %h", tag, f1, f2, f3, f4));
        case (tag)
          32'd1: begin                               // Native pass-through
            rtg_mode.enable = 1'b0;
            osd = '0;
            native_video = video_t'(f1[25:0]);
            hsync_pol = f2[0];
            vsync_pol = f3[0];
            repeat (3) @(negedge clk_114);
            check_value("video_out", f4, {6'b0, video_out});
          end
          32'd2: run_fetch(int'(f1), int'(f2));
          32'd3: begin                               // Hi-colour word held in stream
            rtg_mode.enable    = 1'b1;
            rtg_mode.hicolor16 = f1[0];
            osd = '0;
            hblank = 1'b0;
            native_video.rgb = rgb_t'(f3[23:0]);
            pix_hold_word = f2[15:0];
            pix_hold = 1'b1;
            repeat (5) @(negedge clk_114);
            check_value("video_out.rgb", f4, {8'b0, video_out.rgb});
            hblank = 1'b1;
            repeat (4) @(negedge clk_114);
            check_value("video_out.rgb in hblank", f3, {8'b0, video_out.rgb});
            hblank = 1'b0;
            pix_hold = 1'b0;
          end
          32'd4: begin                               // OSD over native colour
            rtg_mode.enable = 1'b0;
            osd = osd_t'(f1[1:0]);
            native_video.rgb = rgb_t'(f2[23:0]);
            repeat (3) @(negedge clk_114);
            check_value("video_out.rgb", f3, {8'b0, video_out.rgb});
            osd = '0;
          end
          32'd5: run_aux(int'(f1));
          32'd6: run_mix(f1, f2[15:0], f3[15:0], f4[15:0]);
          default: begin
            other_errors++;
            $display("Error: unknown step tag %h in the pattern file", tag);
          end
        endcase
      end
      $fclose(fd);
    end
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verification/av_patterns.txt
# tag 1: video hpol vpol expected_video | tag 2: pixel_width vb_lines
# tag 3: hicolor16 word native_rgb expected_rgb | tag 4: osd native_rgb expected_rgb
# tag 5: pairs | tag 6: amiga_lr aux_word expected_u_l expected_u_r
1 3ABCDEF 0 0 3ABCDEF
1 3ABCDEF 1 0 1ABCDEF
1 3ABCDEF 1 1 0ABCDEF
1 1123456 0 1 0123456
1 2FEDCBA 1 1 1FEDCBA
2 0 2
2 3 3
2 7 1
3 1 F800 123456 FF0000
3 1 07E0 123456 00FF00
3 1 8410 123456 848284
3 0 FC00 123456 FF0000
3 0 4210 123456 848484
4 3 123456 C4CDD5
4 2 123456 040D95
4 1 123456 123456
4 2 FFFFFF 3F3FBF
5 6
6 70007000 0070 FFFF FFFF
6 90009000 0090 0000 0000
6 0010FFF0 0000 8010 7FF0
6 00000000 0010 9000 9000

//--- flist.f
source/av_out_pkg.sv
source/rtg_fetch_timer.sv
source/video_mixer.sv
source/aux_audio_sampler.sv
source/audio_mix_dac.sv
source/av_output_top.sv
verification/av_output_checker.sv
verification/av_output_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass only if the testbench reports a clean run
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f \
  --top-module av_output_tb \
  -o av_output_sim \
  && ./obj_dir/av_output_sim | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
